// ==== source/jump_pkg.sv ====
package jump_pkg;

    // player lanes that share one screen.
    localparam int NUM_PLAYERS = 2;

    // sys_clk cycles per game frame, kept tiny for simulation.
    localparam int TICK_DIV = 8;

    localparam int REFRESH_RATE = 64;  // frames per second.
    localparam int RATE_WIDTH = $clog2(REFRESH_RATE + 1);

    // vertical physics runs in signed units per frame.
    localparam int PHY_WIDTH = 15;
    localparam logic signed [PHY_WIDTH-1:0] MAX_VEL_Y = PHY_WIDTH'(10);

    localparam int X_WIDTH = 8;
    localparam logic [X_WIDTH-1:0] X_MAX = X_WIDTH'(200);
    localparam logic [X_WIDTH-1:0] X_START = X_WIDTH'(100);

    // COLLISION and HOLD are reserved for wall handling.
    typedef enum logic [2:0] {
        IDLE           = 3'd0,
        LEFT           = 3'd1,
        RIGHT          = 3'd2,
        CHARGE         = 3'd3,
        JUMP           = 3'd4,
        COLLISION      = 3'd5,
        FALL_TO_GROUND = 3'd6,
        HOLD           = 3'd7
    } motion_state_e;

    // sprite pose codes as seen by the video side.
    typedef enum logic [2:0] {
        IDLE_DIS_1         = 3'd0,
        IDLE_DIS_2         = 3'd1,
        CHARGE_DIS         = 3'd2,
        JUMP_UP_DIS        = 3'd3,
        JUMP_DOWN_DIS      = 3'd4,
        FALL_TO_GROUND_DIS = 3'd5,
        SAFE_GROUND_DIS    = 3'd6
    } display_pose_e;

endpackage

// ==== source/frame_tick_gen.sv ====
`timescale 1ns/10ps

module frame_tick_gen (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic tick
);

    localparam int CW = $clog2(jump_pkg::TICK_DIV);
    localparam logic [CW-1:0] LAST_CNT = CW'(jump_pkg::TICK_DIV - 1);

    logic [CW-1:0] cnt;

    // tick is registered, so the first pulse lands TICK_DIV cycles after reset.
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == LAST_CNT);
            if (cnt == LAST_CNT) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/button_conditioner.sv ====
`timescale 1ns/10ps

module button_conditioner (
    input  logic                             sys_clk,
    input  logic                             sys_rst_n,
    input  logic                             tick,
    input  logic [jump_pkg::NUM_PLAYERS-1:0] btn_left,
    input  logic [jump_pkg::NUM_PLAYERS-1:0] btn_right,
    input  logic [jump_pkg::NUM_PLAYERS-1:0] btn_jump,
    output logic [jump_pkg::NUM_PLAYERS-1:0] cmd_left,
    output logic [jump_pkg::NUM_PLAYERS-1:0] cmd_right,
    output logic [jump_pkg::NUM_PLAYERS-1:0] cmd_jump
);

    localparam int N = jump_pkg::NUM_PLAYERS;
    localparam int W = 3 * N;

    logic [W-1:0] btn_raw;
    logic [W-1:0] sync_q1;
    logic [W-1:0] sync_q2;
    logic [W-1:0] sticky;
    logic [W-1:0] cmd_q;

    // all buttons of all players share one synchroniser bank.
    assign btn_raw = {btn_jump, btn_right, btn_left};

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= btn_raw;
            sync_q2 <= sync_q1;
        end
    end

    // a short press between two ticks is caught by the sticky bits.
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sticky <= '0;
            cmd_q  <= '0;
        end else if (tick) begin
            cmd_q  <= sticky | sync_q2;
            sticky <= sync_q2;  // a held button stays set into the next frame.
        end else begin
            sticky <= sticky | sync_q2;
        end
    end

    assign cmd_left  = cmd_q[N-1:0];
    assign cmd_right = cmd_q[2*N-1:N];
    assign cmd_jump  = cmd_q[3*N-1:2*N];

endmodule

// ==== source/character_motion.sv ====
`timescale 1ns/10ps

module character_motion (
    input  logic                                 sys_clk,
    input  logic                                 sys_rst_n,
    input  logic                                 frame_tick,
    input  logic                                 cmd_left,
    input  logic                                 cmd_right,
    input  logic                                 cmd_jump,
    output jump_pkg::motion_state_e              char_state,
    output logic signed [jump_pkg::PHY_WIDTH-1:0] vel_y,
    output logic signed [jump_pkg::PHY_WIDTH-1:0] height,
    output logic [jump_pkg::X_WIDTH-1:0]          x_pos
);

    logic signed [jump_pkg::PHY_WIDTH-1:0] charge;
    logic signed [jump_pkg::PHY_WIDTH-1:0] next_height;

    // height one frame ahead if the jump goes on.
    assign next_height = height + vel_y;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            char_state <= jump_pkg::IDLE;
            charge     <= '0;
            vel_y      <= '0;
            height     <= '0;
            x_pos      <= jump_pkg::X_START;
        end else if (frame_tick) begin
            case (char_state)
                jump_pkg::IDLE,
                jump_pkg::LEFT,
                jump_pkg::RIGHT: begin
                    // jump wins over walking when both are held.
                    if (cmd_jump) begin
                        char_state <= jump_pkg::CHARGE;
                        charge     <= 1;
                    end else if (cmd_left) begin
                        char_state <= jump_pkg::LEFT;
                        if (x_pos != '0) begin
                            x_pos <= x_pos - 1'b1;
                        end
                    end else if (cmd_right) begin
                        char_state <= jump_pkg::RIGHT;
                        if (x_pos < jump_pkg::X_MAX) begin
                            x_pos <= x_pos + 1'b1;
                        end
                    end else begin
                        char_state <= jump_pkg::IDLE;
                    end
                end

                jump_pkg::CHARGE: begin
                    if (cmd_jump) begin
                        if (charge < jump_pkg::MAX_VEL_Y) begin
                            charge <= charge + 1'b1;  // charge saturates at MAX_VEL_Y.
                        end
                    end else begin
                        char_state <= jump_pkg::JUMP;
                        vel_y      <= charge;
                    end
                end

                jump_pkg::JUMP: begin
                    if (vel_y < 0 && next_height <= 0) begin
                        // touch down, the ground is at height zero.
                        char_state <= jump_pkg::FALL_TO_GROUND;
                        height     <= '0;
                        vel_y      <= '0;
                    end else begin
                        height <= next_height;
                        vel_y  <= vel_y - 1'b1;  // gravity of one unit per frame.
                    end
                end

                jump_pkg::FALL_TO_GROUND: begin
                    char_state <= jump_pkg::IDLE;
                end

                default: begin
                    // COLLISION and HOLD are not entered without walls.
                    char_state <= jump_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/character_display.sv ====
`timescale 1ns/10ps

module character_display (
    input  logic                                  sys_clk,
    input  logic                                  sys_rst_n,
    input  logic                                  character_clk,
    input  jump_pkg::motion_state_e               char_state,
    input  logic signed [jump_pkg::PHY_WIDTH-1:0] vel_y,
    output jump_pkg::display_pose_e               char_display_id
);

    localparam int RW = jump_pkg::RATE_WIDTH;
    localparam logic [RW-1:0] IDLE_BREATHE_TIME = RW'(jump_pkg::REFRESH_RATE / 2);
    localparam logic [RW-1:0] FALL_TO_GROUND_TIME = RW'(jump_pkg::REFRESH_RATE);
    localparam logic [RW-1:0] LAST_FRAME = RW'(jump_pkg::REFRESH_RATE - 1);
    localparam logic signed [jump_pkg::PHY_WIDTH-1:0] FALLING_VEL_THRESHOLD =
        -(jump_pkg::MAX_VEL_Y >>> 1);

    logic                                  character_clk_d;
    jump_pkg::motion_state_e               char_state_d;
    logic signed [jump_pkg::PHY_WIDTH-1:0] vel_y_d;
    logic signed [jump_pkg::PHY_WIDTH-1:0] vel_y_delay;
    jump_pkg::display_pose_e               display_state;
    jump_pkg::display_pose_e               next_display_state;
    logic [RW-1:0]                         idle_cnt;
    logic [RW-1:0]                         fall_cnt;

    // inputs are sampled once so the pose lags the motion update by a cycle.
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            character_clk_d <= 1'b0;
            char_state_d    <= jump_pkg::IDLE;
            vel_y_d         <= '0;
        end else begin
            character_clk_d <= character_clk;
            char_state_d    <= char_state;
            vel_y_d         <= vel_y;
        end
    end

    // velocity of the previous frame, used to grade the landing.
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vel_y_delay <= '0;
        end else if (character_clk_d) begin
            vel_y_delay <= vel_y_d;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            display_state <= jump_pkg::IDLE_DIS_1;
        end else if (character_clk_d) begin
            display_state <= next_display_state;
        end
    end

    always_comb begin
        next_display_state = jump_pkg::IDLE_DIS_1;
        case (char_state_d)
            jump_pkg::IDLE: begin
                // a landing pose runs out its full hold before breathing resumes.
                if (display_state == jump_pkg::FALL_TO_GROUND_DIS &&
                    fall_cnt < FALL_TO_GROUND_TIME - 1'b1) begin
                    next_display_state = jump_pkg::FALL_TO_GROUND_DIS;
                end else if (display_state == jump_pkg::SAFE_GROUND_DIS &&
                             fall_cnt < FALL_TO_GROUND_TIME - 1'b1) begin
                    next_display_state = jump_pkg::SAFE_GROUND_DIS;
                end else if (vel_y_d > 0) begin
                    next_display_state = jump_pkg::JUMP_UP_DIS;
                end else if (vel_y_d < 0) begin
                    next_display_state = jump_pkg::JUMP_DOWN_DIS;
                end else if (idle_cnt < IDLE_BREATHE_TIME) begin
                    next_display_state = jump_pkg::IDLE_DIS_1;
                end else begin
                    next_display_state = jump_pkg::IDLE_DIS_2;
                end
            end
            jump_pkg::CHARGE: begin
                next_display_state = jump_pkg::CHARGE_DIS;
            end
            jump_pkg::JUMP: begin
                if (vel_y_d > 0) begin
                    next_display_state = jump_pkg::JUMP_UP_DIS;
                end else if (vel_y_d < 0) begin
                    next_display_state = jump_pkg::JUMP_DOWN_DIS;
                end else begin
                    next_display_state = display_state;  // apex keeps the last pose.
                end
            end
            jump_pkg::FALL_TO_GROUND: begin
                if (vel_y_delay == 0) begin
                    next_display_state = display_state;
                end else if (vel_y_delay < FALLING_VEL_THRESHOLD) begin
                    next_display_state = jump_pkg::FALL_TO_GROUND_DIS;
                end else begin
                    next_display_state = jump_pkg::SAFE_GROUND_DIS;
                end
            end
            default: begin
                next_display_state = jump_pkg::IDLE_DIS_1;
            end
        endcase
    end

    assign char_display_id = display_state;

    // free-running breathing phase, one count per frame.
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            idle_cnt <= '0;
        end else if (character_clk_d) begin
            idle_cnt <= (idle_cnt == LAST_FRAME) ? '0 : idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            fall_cnt <= '0;
        end else if (character_clk_d) begin
            if (display_state == jump_pkg::FALL_TO_GROUND_DIS ||
                display_state == jump_pkg::SAFE_GROUND_DIS) begin
                fall_cnt <= fall_cnt + 1'b1;
            end else begin
                fall_cnt <= '0;
            end
        end
    end

endmodule

// ==== source/sprite_frame_packer.sv ====
`timescale 1ns/10ps

module sprite_frame_packer (
    input  logic                                                 sys_clk,
    input  logic                                                 sys_rst_n,
    input  logic                                                 tick,
    input  logic [3*jump_pkg::NUM_PLAYERS-1:0]                   pose_in,
    input  logic [jump_pkg::PHY_WIDTH*jump_pkg::NUM_PLAYERS-1:0] height_in,
    input  logic [jump_pkg::X_WIDTH*jump_pkg::NUM_PLAYERS-1:0]   x_in,
    output logic                                                 frame_valid,
    output logic [3*jump_pkg::NUM_PLAYERS-1:0]                   pose_ids,
    output logic [jump_pkg::PHY_WIDTH*jump_pkg::NUM_PLAYERS-1:0] heights,
    output logic [jump_pkg::X_WIDTH*jump_pkg::NUM_PLAYERS-1:0]   x_positions
);

    logic [1:0] tick_sr;

    // two stages give the pose logic time to settle after the motion step.
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tick_sr     <= '0;
            frame_valid <= 1'b0;
        end else begin
            tick_sr     <= {tick_sr[0], tick};
            frame_valid <= tick_sr[1];
        end
    end

    // frame registers hold between strobes for the video side.
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pose_ids    <= '0;  // IDLE_DIS_1 in every lane.
            heights     <= '0;
            x_positions <= {jump_pkg::NUM_PLAYERS{jump_pkg::X_START}};
        end else if (tick_sr[1]) begin
            pose_ids    <= pose_in;
            heights     <= height_in;
            x_positions <= x_in;
        end
    end

endmodule

// ==== source/jump_game_top.sv ====
`timescale 1ns/10ps

module jump_game_top (
    input  logic                                                 sys_clk,
    input  logic                                                 sys_rst_n,
    input  logic [jump_pkg::NUM_PLAYERS-1:0]                     btn_left,
    input  logic [jump_pkg::NUM_PLAYERS-1:0]                     btn_right,
    input  logic [jump_pkg::NUM_PLAYERS-1:0]                     btn_jump,
    output logic                                                 frame_valid,
    output logic [3*jump_pkg::NUM_PLAYERS-1:0]                   pose_ids,
    output logic [jump_pkg::PHY_WIDTH*jump_pkg::NUM_PLAYERS-1:0] heights,
    output logic [jump_pkg::X_WIDTH*jump_pkg::NUM_PLAYERS-1:0]   x_positions
);

    localparam int PW = jump_pkg::PHY_WIDTH;
    localparam int XW = jump_pkg::X_WIDTH;

    logic                                 tick;
    logic [jump_pkg::NUM_PLAYERS-1:0]     cmd_left;
    logic [jump_pkg::NUM_PLAYERS-1:0]     cmd_right;
    logic [jump_pkg::NUM_PLAYERS-1:0]     cmd_jump;
    logic [3*jump_pkg::NUM_PLAYERS-1:0]   pose_all;
    logic [PW*jump_pkg::NUM_PLAYERS-1:0]  height_all;
    logic [XW*jump_pkg::NUM_PLAYERS-1:0]  x_all;

    frame_tick_gen u_tick_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (tick)
    );

    button_conditioner u_buttons (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (tick),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .cmd_left  (cmd_left),
        .cmd_right (cmd_right),
        .cmd_jump  (cmd_jump)
    );

    // one motion and pose pair per player lane.
    for (genvar i = 0; i < jump_pkg::NUM_PLAYERS; i++) begin : g_player
        jump_pkg::motion_state_e char_state;
        logic signed [PW-1:0]    vel_y;

        character_motion u_motion (
            .sys_clk    (sys_clk),
            .sys_rst_n  (sys_rst_n),
            .frame_tick (tick),
            .cmd_left   (cmd_left[i]),
            .cmd_right  (cmd_right[i]),
            .cmd_jump   (cmd_jump[i]),
            .char_state (char_state),
            .vel_y      (vel_y),
            .height     (height_all[i*PW +: PW]),
            .x_pos      (x_all[i*XW +: XW])
        );

        character_display u_display (
            .sys_clk         (sys_clk),
            .sys_rst_n       (sys_rst_n),
            .character_clk   (tick),
            .char_state      (char_state),
            .vel_y           (vel_y),
            .char_display_id (pose_all[i*3 +: 3])
        );
    end

    sprite_frame_packer u_packer (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .tick        (tick),
        .pose_in     (pose_all),
        .height_in   (height_all),
        .x_in        (x_all),
        .frame_valid (frame_valid),
        .pose_ids    (pose_ids),
        .heights     (heights),
        .x_positions (x_positions)
    );

endmodule

// ==== testbench/jump_game_chk.sv ====
`timescale 1ns/10ps

module jump_game_chk (
    input logic                                                 sys_clk,
    input logic                                                 sys_rst_n,
    input logic                                                 tick,
    input logic                                                 frame_valid,
    input logic [3*jump_pkg::NUM_PLAYERS-1:0]                   pose_ids,
    input logic [jump_pkg::PHY_WIDTH*jump_pkg::NUM_PLAYERS-1:0] heights
);

    localparam int PW = jump_pkg::PHY_WIDTH;

    a_fv_after_tick: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tick |-> ##3 frame_valid)
        else $error("frame_valid did not follow tick by three cycles");

    a_fv_has_tick: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        frame_valid |-> $past(tick, 3))
        else $error("frame_valid without a tick three cycles before");

    a_fv_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        frame_valid |=> !frame_valid)
        else $error("frame_valid wider than one cycle");

    // each lane is checked on its own.
    for (genvar i = 0; i < jump_pkg::NUM_PLAYERS; i++) begin : g_lane
        a_pose_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            pose_ids[i*3 +: 3] != 3'd7)
            else $error("illegal pose code in lane %0d", i);

        a_height_positive: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            !heights[i*PW + PW - 1])
            else $error("negative height in lane %0d", i);
    end

endmodule

bind jump_game_top jump_game_chk u_chk (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .tick        (tick),
    .frame_valid (frame_valid),
    .pose_ids    (pose_ids),
    .heights     (heights)
);

// ==== testbench/tb_jump_game.sv ====
`timescale 1ns/10ps

module tb_jump_game;

    localparam int N = jump_pkg::NUM_PLAYERS;
    localparam int PW = jump_pkg::PHY_WIDTH;
    localparam int XW = jump_pkg::X_WIDTH;
    localparam int WAIT_LIMIT = 4 * jump_pkg::TICK_DIV;

    typedef struct {
        logic [N-1:0] left;
        logic [N-1:0] right;
        logic [N-1:0] jump;
        int           frames;
        int           pose0;
        int           pose1;
        int           h0;
        int           h1;
        int           x0;
        int           x1;
    } step_t;

    logic                 sys_clk;
    logic                 sys_rst_n;
    logic [N-1:0]         btn_left;
    logic [N-1:0]         btn_right;
    logic [N-1:0]         btn_jump;
    logic                 frame_valid;
    logic [3*N-1:0]       pose_ids;
    logic [PW*N-1:0]      heights;
    logic [XW*N-1:0]      x_positions;

    step_t steps[$];
    int    error_count;
    int    timeout_count;
    bit    timed_out;

    jump_game_top DUT (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .btn_jump    (btn_jump),
        .frame_valid (frame_valid),
        .pose_ids    (pose_ids),
        .heights     (heights),
        .x_positions (x_positions)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    task automatic add_step(input logic [N-1:0] l, input logic [N-1:0] r,
                            input logic [N-1:0] j, input int frames,
                            input int p0, input int p1, input int h0, input int h1,
                            input int x0, input int x1);
        step_t s;
        s.left   = l;
        s.right  = r;
        s.jump   = j;
        s.frames = frames;
        s.pose0  = p0;
        s.pose1  = p1;
        s.h0     = h0;
        s.h1     = h1;
        s.x0     = x0;
        s.x1     = x1;
        steps.push_back(s);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERROR time %0t %s expected %0d actual %0d",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // returns at the falling edge where frame_valid is seen high.
    task automatic wait_frame();
        int cycles;
        cycles = 0;
        @(negedge sys_clk);
        while (!frame_valid && cycles < WAIT_LIMIT) begin
            @(negedge sys_clk);
            cycles++;
        end
        if (!frame_valid) begin
            $display("timeout: no frame_valid pulse within %0d clock cycles", WAIT_LIMIT);
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_frame(input step_t s);
        logic signed [PW-1:0] h;
        check_value("pose_ids[0]", s.pose0, int'(pose_ids[2:0]));
        check_value("pose_ids[1]", s.pose1, int'(pose_ids[5:3]));
        h = heights[PW-1:0];
        check_value("heights[0]", s.h0, int'(h));
        h = heights[2*PW-1:PW];
        check_value("heights[1]", s.h1, int'(h));
        check_value("x_positions[0]", s.x0, int'(x_positions[XW-1:0]));
        check_value("x_positions[1]", s.x1, int'(x_positions[2*XW-1:XW]));
    endtask

    // pose codes: 0 idle 1, 1 idle 2, 2 charge, 3 up, 4 down, 5 hard land, 6 soft land.
    task automatic build_table();
        add_step(2'b00, 2'b00, 2'b00, 1, 0, 0, 0, 0, 100, 100);
        add_step(2'b00, 2'b00, 2'b00, 31, 0, 0, 0, 0, 100, 100);
        add_step(2'b00, 2'b00, 2'b00, 1, 1, 1, 0, 0, 100, 100);
        add_step(2'b01, 2'b10, 2'b00, 2, 1, 1, 0, 0, 99, 101);   // walking starts.
        add_step(2'b01, 2'b00, 2'b00, 2, 0, 0, 0, 0, 97, 103);
        add_step(2'b00, 2'b00, 2'b00, 4, 1, 1, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b01, 1, 1, 1, 0, 0, 95, 103);   // charge of three.
        add_step(2'b00, 2'b00, 2'b01, 1, 1, 1, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 2, 1, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 2, 2, 1, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 3, 1, 3, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 3, 1, 5, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 3, 1, 6, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 3, 1, 6, 0, 95, 103);   // apex keeps the up pose.
        add_step(2'b00, 2'b00, 2'b00, 1, 4, 1, 5, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 4, 1, 3, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 4, 1, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 6, 1, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 63, 6, 1, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 1, 1, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b01, 15, 2, 0, 0, 0, 95, 103);  // charge hits the cap.
        add_step(2'b00, 2'b00, 2'b00, 13, 3, 0, 55, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 3, 0, 55, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 11, 5, 0, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 63, 5, 0, 0, 0, 95, 103);
        add_step(2'b00, 2'b00, 2'b00, 1, 0, 0, 0, 0, 95, 103);
    endtask

    initial begin
        int idx;
        btn_left      = '0;
        btn_right     = '0;
        btn_jump      = '0;
        sys_rst_n     = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        timed_out     = 1'b0;
        build_table();
        repeat (10) @(posedge sys_clk);
        #1 sys_rst_n = 1'b1;

        @(negedge sys_clk);
        assert (frame_valid == 1'b0) else begin
            $display("ERROR time %0t frame_valid expected 0 actual %0d", $time, frame_valid);
            error_count++;
        end

        idx = 0;
        while (idx < steps.size() && !timed_out) begin
            @(posedge sys_clk);
            #1;
            btn_left  = steps[idx].left;
            btn_right = steps[idx].right;
            btn_jump  = steps[idx].jump;
            for (int f = 0; f < steps[idx].frames && !timed_out; f++) begin
                wait_frame();
            end
            if (!timed_out) begin
                check_frame(steps[idx]);
            end
            idx++;
        end

        $display("errors: %0d check failures, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
source/jump_pkg.sv
source/frame_tick_gen.sv
source/button_conditioner.sv
source/character_motion.sv
source/character_display.sv
source/sprite_frame_packer.sv
source/jump_game_top.sv
testbench/jump_game_chk.sv
testbench/tb_jump_game.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_jump_game

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_jump_game -f files.f

run: build
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

lint:
	verilator --lint-only --timing --assert --top-module tb_jump_game -f files.f

clean:
	rm -rf obj_dir
